// File: logic/icache_pkg.sv
package icache_pkg;

  //////////////////////////////////////////////////
  // Cache geometry
  //////////////////////////////////////////////////

  localparam int word_w     = 32;
  localparam int num_ways   = 4;
  localparam int num_sets   = 16;
  localparam int line_words = 16;

  localparam int offset_w = $clog2(line_words);
  localparam int index_w  = $clog2(num_sets);

  // Byte bits sit below the word offset
  localparam int offset_lsb = 2;
  localparam int index_lsb  = offset_lsb + offset_w;
  localparam int tag_lsb    = index_lsb + index_w;
  localparam int tag_w      = word_w - tag_lsb;

  //////////////////////////////////////////////////
  // Field and vector types
  //////////////////////////////////////////////////

  typedef logic [word_w-1:0]   word_t;
  typedef logic [tag_w-1:0]    tag_t;
  typedef logic [index_w-1:0]  index_t;
  typedef logic [offset_w-1:0] offset_t;

  typedef logic [$clog2(num_ways)-1:0] way_t;

  // Recency rank where 0 is the most recently served way
  typedef logic [$clog2(num_ways)-1:0] age_t;

  typedef logic [num_ways-1:0] way_mask_t;

  // One entry per way
  typedef tag_t  [num_ways-1:0] tag_vec_t;
  typedef age_t  [num_ways-1:0] age_vec_t;
  typedef word_t [num_ways-1:0] word_vec_t;

endpackage

// File: logic/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup import icache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  word_t     insaddr,
  input  tag_vec_t  rd_tags,
  input  way_mask_t rd_valid,
  input  age_vec_t  rd_ages,
  input  word_vec_t rd_words,
  input  logic      fill_done,
  output logic      ok,
  output logic      miss,
  output word_t     ins,
  output index_t    rd_index,
  output offset_t   rd_offset,
  output logic      age_we,
  output index_t    age_index,
  output age_vec_t  age_new,
  output logic      fill_start,
  output way_t      fill_way,
  output word_t     fill_addr
);

  enum logic [1:0] {idle, compare, wait_fill} state;

  word_t     req_addr;
  tag_t      req_tag;
  way_mask_t hit_mask;
  logic      hit;
  way_t      hit_way;
  way_t      victim;
  logic      accept;

  // No new request while the previous ok is still up
  assign accept = (state == idle) && req && !ok;

  // Idle reads from the live address so data arrive in compare
  assign rd_index  = (state == idle) ? insaddr[index_lsb +: index_w]
                                     : req_addr[index_lsb +: index_w];
  assign rd_offset = (state == idle) ? insaddr[offset_lsb +: offset_w]
                                     : req_addr[offset_lsb +: offset_w];

  assign req_tag = req_addr[tag_lsb +: tag_w];

  //////////////////////////////////////////////////
  // Tag compare and way choice
  //////////////////////////////////////////////////

  always_comb
  begin
    hit_way = '0;
    victim  = '0;
    for (int w = 0; w < num_ways; w++)
      hit_mask[w] = rd_valid[w] && (rd_tags[w] == req_tag);
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (hit_mask[w])
        hit_way = way_t'(w);
      if (rd_ages[w] == age_t'(num_ways - 1))
        victim = way_t'(w);
    end
    // An empty way beats the oldest one
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (!rd_valid[w])
        victim = way_t'(w);
    end
  end

  assign hit = |hit_mask;

  // Served way drops to 0 and younger ways age by one
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      if (way_t'(w) == hit_way)
        age_new[w] = '0;
      else if (rd_ages[w] < rd_ages[hit_way])
        age_new[w] = rd_ages[w] + age_t'(1);
      else
        age_new[w] = rd_ages[w];
    end
  end

  assign age_we    = (state == compare) && hit;
  assign age_index = req_addr[index_lsb +: index_w];
  assign fill_addr = req_addr;

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= idle;
      ok         <= 1'b0;
      miss       <= 1'b0;
      fill_start <= 1'b0;
    end
    else
    begin
      ok         <= 1'b0;
      miss       <= 1'b0;
      fill_start <= 1'b0;
      case (state)
        idle:
          if (accept)
            state <= compare;
        compare:
          if (hit)
          begin
            ok    <= 1'b1;
            state <= idle;
          end
          else
          begin
            miss       <= 1'b1;
            fill_start <= 1'b1;
            state      <= wait_fill;
          end
        wait_fill:
          if (fill_done)
            state <= compare;
        default:
          state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      req_addr <= insaddr;
    if (state == compare && hit)
      ins <= rd_words[hit_way];
    if (state == compare && !hit)
      fill_way <= victim;
  end

  // A line lives in at most one way of its set
  assert property (@(posedge clk) disable iff (rst) (state == compare) |-> $onehot0(hit_mask));

endmodule

// File: logic/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    fill_start,
  input  way_t    fill_way,
  input  word_t   fill_addr,
  input  logic    data_ok,
  input  word_t   sdata,
  output logic    sen,
  output word_t   addr,
  output logic    fill_done,
  output logic    wr_en,
  output way_t    wr_way,
  output index_t  wr_index,
  output offset_t wr_offset,
  output word_t   wr_word,
  output logic    tag_we,
  output tag_t    wr_tag
);

  word_t   miss_addr;
  way_t    miss_way;
  offset_t beat;
  logic    last_beat;

  // A beat is taken on every edge with sen and data_ok
  assign wr_en     = sen && data_ok;
  assign last_beat = beat == offset_t'(line_words - 1);

  //////////////////////////////////////////////////
  // Beat counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sen       <= 1'b0;
      beat      <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= 1'b0;
      if (fill_start)
      begin
        sen  <= 1'b1;
        beat <= '0;
      end
      else if (wr_en)
      begin
        beat <= beat + offset_t'(1);
        if (last_beat)
        begin
          sen       <= 1'b0;
          fill_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_start)
    begin
      miss_addr <= fill_addr;
      miss_way  <= fill_way;
    end
  end

  //////////////////////////////////////////////////
  // Array write port
  //////////////////////////////////////////////////

  assign addr     = miss_addr;
  assign wr_way   = miss_way;
  assign wr_index = miss_addr[index_lsb +: index_w];

  // Burst starts at the missed word and wraps in the line
  assign wr_offset = miss_addr[offset_lsb +: offset_w] + beat;
  assign wr_word   = sdata;

  // Tag and valid land with the final word
  assign tag_we = wr_en && last_beat;
  assign wr_tag = miss_addr[tag_lsb +: tag_w];

  assert property (@(posedge clk) disable iff (rst) fill_start |-> !sen);

endmodule

// File: logic/icache_ways.sv
`timescale 1ns/1ps

module icache_ways import icache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  index_t    rd_index,
  input  offset_t   rd_offset,
  input  logic      age_we,
  input  index_t    age_index,
  input  age_vec_t  age_new,
  input  logic      wr_en,
  input  way_t      wr_way,
  input  index_t    wr_index,
  input  offset_t   wr_offset,
  input  word_t     wr_word,
  input  logic      tag_we,
  input  tag_t      wr_tag,
  output tag_vec_t  rd_tags,
  output way_mask_t rd_valid,
  output age_vec_t  rd_ages,
  output word_vec_t rd_words
);

  tag_t      tag_mem  [num_ways][num_sets];
  word_t     data_mem [num_ways][num_sets * line_words];
  way_mask_t valid    [num_sets];
  age_vec_t  ages     [num_sets];

  logic [num_ways-1:0] age_seen;

  //////////////////////////////////////////////////
  // Tag and data RAMs
  //////////////////////////////////////////////////

  // Word address is index then offset
  always_ff @(posedge clk)
  begin
    if (tag_we)
      tag_mem[wr_way][wr_index] <= wr_tag;
    if (wr_en)
      data_mem[wr_way][{wr_index, wr_offset}] <= wr_word;
    for (int w = 0; w < num_ways; w++)
    begin
      rd_tags[w]  <= tag_mem[w][rd_index];
      rd_words[w] <= data_mem[w][{rd_index, rd_offset}];
    end
  end

  //////////////////////////////////////////////////
  // Valid bits and ages
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
      begin
        valid[s] <= '0;
        // Start each set as a valid rank order
        for (int w = 0; w < num_ways; w++)
          ages[s][w] <= age_t'(w);
      end
      rd_valid <= '0;
      rd_ages  <= '0;
    end
    else
    begin
      if (tag_we)
        valid[wr_index][wr_way] <= 1'b1;
      if (age_we)
        ages[age_index] <= age_new;
      rd_valid <= valid[rd_index];
      rd_ages  <= ages[rd_index];
    end
  end

  // One bit per rank that appears in the new vector
  always_comb
  begin
    age_seen = '0;
    for (int w = 0; w < num_ways; w++)
      age_seen[age_new[w]] = 1'b1;
  end

  assert property (@(posedge clk) disable iff (rst) age_we |-> &age_seen);

endmodule

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  input  word_t insaddr,
  output word_t ins,
  output logic  ok,
  output logic  miss,
  output logic  sen,
  output word_t addr,
  input  logic  data_ok,
  input  word_t sdata
);

  // Lookup and ways
  index_t    rd_index;
  offset_t   rd_offset;
  tag_vec_t  rd_tags;
  way_mask_t rd_valid;
  age_vec_t  rd_ages;
  word_vec_t rd_words;
  logic      age_we;
  index_t    age_index;
  age_vec_t  age_new;

  // Lookup and refill
  logic  fill_start;
  way_t  fill_way;
  word_t fill_addr;
  logic  fill_done;

  // Refill and ways
  logic    wr_en;
  way_t    wr_way;
  index_t  wr_index;
  offset_t wr_offset;
  word_t   wr_word;
  logic    tag_we;
  tag_t    wr_tag;

  icache_lookup lookup0 (
    .clk, .rst, .req, .insaddr, .rd_tags, .rd_valid, .rd_ages, .rd_words,
    .fill_done, .ok, .miss, .ins, .rd_index, .rd_offset, .age_we,
    .age_index, .age_new, .fill_start, .fill_way, .fill_addr
  );

  icache_refill refill0 (
    .clk, .rst, .fill_start, .fill_way, .fill_addr, .data_ok, .sdata,
    .sen, .addr, .fill_done, .wr_en, .wr_way, .wr_index, .wr_offset,
    .wr_word, .tag_we, .wr_tag
  );

  icache_ways ways0 (
    .clk, .rst, .rd_index, .rd_offset, .age_we, .age_index, .age_new,
    .wr_en, .wr_way, .wr_index, .wr_offset, .wr_word, .tag_we, .wr_tag,
    .rd_tags, .rd_valid, .rd_ages, .rd_words
  );

endmodule

// File: testbench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

  localparam int max_vectors       = 64;
  localparam int cycles_per_vector = 60;

  logic  clk = 1'b0;
  logic  rst;
  logic  req;
  word_t insaddr;
  word_t ins;
  logic  ok;
  logic  miss;
  logic  sen;
  word_t addr;
  logic  data_ok = 1'b0;
  word_t sdata = '0;

  // Address, expected instruction, expected miss flag
  word_t stim [3*max_vectors];
  int    vec_count = 0;
  int    total_beats = 0;
  int    burst_pos = 0;
  word_t cur_addr = '0;

  icache_top dut0 (
    .clk, .rst, .req, .insaddr, .ins, .ok, .miss, .sen, .addr, .data_ok, .sdata
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t got, input word_t expected);
    if (got !== expected)
      abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got,
                          expected));
  endtask

  // Memory contents are the address with a fixed pattern
  function automatic word_t beat_word(input word_t base, input int pos);
    word_t a;
    a = base;
    a[offset_lsb +: offset_w] = base[offset_lsb +: offset_w] + offset_t'(pos);
    return a ^ 32'h3c5a0000;
  endfunction

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!sen)
    begin
      burst_pos = 0;
      data_ok <= 1'b0;
    end
    else
    begin
      check_value("addr", addr, cur_addr);
      if (data_ok)
      begin
        burst_pos = burst_pos + 1;
        total_beats <= total_beats + 1;
      end
      if (burst_pos < line_words)
      begin
        data_ok <= ($urandom % 4) != 0;
        sdata   <= beat_word(addr, burst_pos);
      end
      else
        data_ok <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Requests
  //////////////////////////////////////////////////

  task automatic run_request(input word_t a, input word_t exp_ins, input word_t exp_miss);
    int   cycles;
    int   beats_start;
    logic seen_miss;
    logic seen_sen;
    logic done;
    cycles    = 0;
    seen_miss = 1'b0;
    seen_sen  = 1'b0;
    done      = 1'b0;
    @(posedge clk);
    beats_start = total_beats;
    cur_addr <= a;
    req      <= 1'b1;
    insaddr  <= a;
    while (!done)
    begin
      @(posedge clk);
      cycles++;
      if (miss)
        seen_miss = 1'b1;
      if (sen)
        seen_sen = 1'b1;
      if (ok)
      begin
        done = 1'b1;
        req <= 1'b0;
        check_value("ins", ins, exp_ins);
      end
    end
    check_value("miss", word_t'(seen_miss), exp_miss);
    if (exp_miss[0])
      check_value("beats", word_t'(total_beats - beats_start), word_t'(line_words));
    else
    begin
      check_value("sen", word_t'(seen_sen), '0);
      // Sampled one edge after the drive, ok two edges later
      check_value("ok latency", word_t'(cycles), word_t'(3));
    end
  endtask

  initial
  begin
    rst     = 1'b1;
    req     = 1'b0;
    insaddr = '0;
    void'($urandom(32'h1a8e));
    for (int i = 0; i < 3*max_vectors; i++)
      stim[i] = '1;
    $readmemh("testbench/icache_stim.txt", stim);
    while (vec_count < max_vectors && stim[3*vec_count+2] <= word_t'(1))
      vec_count++;
    if (vec_count == 0)
      abort_run("No stimulus vectors could be read from testbench/icache_stim.txt");

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("ok", word_t'(ok), '0);
    check_value("miss", word_t'(miss), '0);
    check_value("sen", word_t'(sen), '0);

    for (int i = 0; i < vec_count; i++)
      run_request(stim[3*i], stim[3*i+1], stim[3*i+2]);

    $display("Simulation completed successfully");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (vec_count > 0);
    repeat (vec_count * cycles_per_vector + 10) @(posedge clk);
    abort_run($sformatf("Timeout: %0d requests did not finish within %0d cycles", vec_count,
                        vec_count * cycles_per_vector + 10));
  end

endmodule

// File: testbench/icache_stim.txt
// Columns: request address, expected instruction, expected miss flag
// Expected instruction is the address XOR 3c5a0000
000004d4 3c5a04d4 1
000004c0 3c5a04c0 0
000004fc 3c5a04fc 0
000004d8 3c5a04d8 0
// Four lines in set 3 fill ways 1, 2 and 3
000008c0 3c5a08c0 1
00000cc8 3c5a0cc8 1
000010e4 3c5a10e4 1
000008c4 3c5a08c4 0
000004d0 3c5a04d0 0
000010fc 3c5a10fc 0
00000cc0 3c5a0cc0 0
// Fifth line evicts way 1, then the re-read evicts way 0
000014dc 3c5a14dc 1
000008c8 3c5a08c8 1
00000ccc 3c5a0ccc 0
000010c0 3c5a10c0 0
000014c4 3c5a14c4 0
000008cc 3c5a08cc 0
000004d4 3c5a04d4 1
// Another set
12345678 2e6e5678 1
12345640 2e6e5640 0

// File: verilog.f
logic/icache_pkg.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_ways.sv
logic/icache_top.sv
testbench/icache_tb.sv

// File: Makefile
SIM       ?= verilator
TOP       ?= icache_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
